// ==== verilog/pong_cfg.svh ====
`ifndef PONG_CFG_SVH
`define PONG_CFG_SVH

// screen size in pixels
`define SCREEN_X 320
`define SCREEN_Y 240

// object sizes
`define BALL_SIZE 4
`define PADDLE_W 5
`define PADDLE_H 40

// register widths
`define COLOUR_W 3
`define PERIOD_W 24

// 60 frames per second at 50 MHz
`define FRAME_PERIOD_RST 833333

// reset colours
`define BG_COLOUR_RST 0
`define PADDLE_COLOUR_RST 7
`define BALL_COLOUR_RST 2

`endif

// ==== verilog/pong_pkg.sv ====
`default_nettype none

`include "pong_cfg.svh"

package pong_pkg;

	typedef logic [8:0] coord_x_t;
	typedef logic [7:0] coord_y_t;
	typedef logic [`COLOUR_W-1:0] colour_t;
	typedef logic [`PERIOD_W-1:0] period_t;

	// one pixel on its way to the display writer
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		colour_t colour;
	} pixel_t;

	// rectangle to fill from its top left corner
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		coord_x_t width;
		coord_y_t height;
		colour_t colour;
	} box_req_t;

	// paddle x positions are fixed, so only y travels
	typedef struct packed {
		coord_y_t paddle1_y;
		coord_y_t paddle2_y;
		coord_x_t ball_x;
		coord_y_t ball_y;
	} obj_pos_t;

	typedef struct packed {
		period_t frame_period;
		colour_t bg_colour;
		colour_t paddle_colour;
		colour_t ball_colour;
	} render_cfg_t;

	typedef enum logic [2:0] {
		IDLE,
		BLANK,
		P1_CLEAR,
		P1_DRAW,
		P2_CLEAR,
		P2_DRAW,
		BALL_CLEAR,
		BALL_DRAW
	} draw_state_t;

endpackage

`default_nettype wire

// ==== verilog/frame_timer.sv ====
`default_nettype none

module frame_timer (
	input logic clk,
	input logic resetn,
	input pong_pkg::period_t frame_period,
	output logic frame_tick
);
	import pong_pkg::*;

	period_t count;

	// new period is only picked up on reload
	always_ff @(posedge clk) begin
		if (!resetn) begin
			count <= frame_period - 1'b1;
			frame_tick <= 1'b0;
		end else if (count == '0) begin
			count <= frame_period - 1'b1;
			frame_tick <= 1'b1;
		end else begin
			count <= count - 1'b1;
			frame_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/render_regs.sv ====
`default_nettype none

`include "pong_cfg.svh"

module render_regs (
	input logic clk,
	input logic resetn,
	input logic cfg_we,
	input logic [1:0] cfg_addr,
	input logic [31:0] cfg_wdata,
	output pong_pkg::render_cfg_t cfg
);
	import pong_pkg::*;

	period_t wr_period;
	colour_t wr_colour;

	// shortest period the timer can turn around in
	assign wr_period = (cfg_wdata[`PERIOD_W-1:0] < period_t'(2)) ?
		period_t'(2) : cfg_wdata[`PERIOD_W-1:0];
	assign wr_colour = cfg_wdata[`COLOUR_W-1:0];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cfg.frame_period <= period_t'(`FRAME_PERIOD_RST);
			cfg.bg_colour <= colour_t'(`BG_COLOUR_RST);
			cfg.paddle_colour <= colour_t'(`PADDLE_COLOUR_RST);
			cfg.ball_colour <= colour_t'(`BALL_COLOUR_RST);
		end else if (cfg_we) begin
			case (cfg_addr)
				2'd0: begin
					cfg.frame_period <= wr_period;
				end
				2'd1: begin
					cfg.bg_colour <= wr_colour;
				end
				2'd2: begin
					cfg.paddle_colour <= wr_colour;
				end
				default: begin
					cfg.ball_colour <= wr_colour;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/render_sequencer.sv ====
`default_nettype none

`include "pong_cfg.svh"

module render_sequencer (
	input logic clk,
	input logic resetn,
	input logic frame_tick,
	input logic score,
	input pong_pkg::obj_pos_t objs,
	input pong_pkg::render_cfg_t cfg,
	output pong_pkg::box_req_t box,
	output logic box_valid,
	input logic box_ready
);
	import pong_pkg::*;

	localparam coord_x_t P1_X = coord_x_t'(2);
	localparam coord_x_t P2_X = coord_x_t'(`SCREEN_X - `PADDLE_W);
	localparam coord_x_t PAD_W = coord_x_t'(`PADDLE_W);
	localparam coord_y_t PAD_H = coord_y_t'(`PADDLE_H);
	localparam coord_x_t BALL_W = coord_x_t'(`BALL_SIZE);
	localparam coord_y_t BALL_H = coord_y_t'(`BALL_SIZE);

	draw_state_t state;
	draw_state_t next_state;
	obj_pos_t cur_pos;
	obj_pos_t prev_pos;
	obj_pos_t sel_pos;
	box_req_t next_box;
	logic score_pending;
	logic pending_now;
	logic started;
	logic box_done;

	assign pending_now = score_pending | score;
	assign box_done = box_valid & box_ready;

	always_comb begin
		case (state)
			IDLE: next_state = pending_now ? BLANK : P1_CLEAR;
			// the blank after reset is not part of a frame
			BLANK: next_state = started ? P1_CLEAR : IDLE;
			P1_CLEAR: next_state = P1_DRAW;
			P1_DRAW: next_state = P2_CLEAR;
			P2_CLEAR: next_state = P2_DRAW;
			P2_DRAW: next_state = BALL_CLEAR;
			BALL_CLEAR: next_state = BALL_DRAW;
			default: next_state = IDLE;
		endcase
	end

	// draw states use the new positions, clear states the old ones
	assign sel_pos = (state == P1_DRAW || state == P2_DRAW || state == BALL_DRAW) ?
		cur_pos : prev_pos;

	always_comb begin
		next_box.x = sel_pos.ball_x;
		next_box.y = sel_pos.ball_y;
		next_box.width = BALL_W;
		next_box.height = BALL_H;
		next_box.colour = cfg.bg_colour;
		case (state)
			BLANK: begin
				next_box.x = '0;
				next_box.y = '0;
				next_box.width = coord_x_t'(`SCREEN_X);
				next_box.height = coord_y_t'(`SCREEN_Y);
			end
			P1_CLEAR, P1_DRAW: begin
				next_box.x = P1_X;
				next_box.y = sel_pos.paddle1_y;
				next_box.width = PAD_W;
				next_box.height = PAD_H;
			end
			P2_CLEAR, P2_DRAW: begin
				next_box.x = P2_X;
				next_box.y = sel_pos.paddle2_y;
				next_box.width = PAD_W;
				next_box.height = PAD_H;
			end
			default: begin
			end
		endcase
		if (state == P1_DRAW || state == P2_DRAW) begin
			next_box.colour = cfg.paddle_colour;
		end else if (state == BALL_DRAW) begin
			next_box.colour = cfg.ball_colour;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= BLANK;
			box_valid <= 1'b0;
			score_pending <= 1'b0;
			started <= 1'b0;
			cur_pos <= '0;
			prev_pos <= '0;
		end else if (state == IDLE) begin
			score_pending <= pending_now & ~frame_tick;
			if (frame_tick) begin
				state <= next_state;
				started <= 1'b1;
				cur_pos <= objs;
				prev_pos <= cur_pos;
			end
		end else begin
			// ticks are dropped here, scores are kept
			score_pending <= pending_now;
			if (!box_valid) begin
				box_valid <= 1'b1;
			end else if (box_done) begin
				box_valid <= 1'b0;
				state <= next_state;
			end
		end
	end

	// request is frozen once offered
	always_ff @(posedge clk) begin
		if (state != IDLE && !box_valid) begin
			box <= next_box;
		end
	end

	a_box_hold: assert property (@(posedge clk) disable iff (!resetn)
		box_valid && !box_ready |=> box_valid && $stable(box))
		else $error("box changed while stalled");

	a_box_fits: assert property (@(posedge clk) disable iff (!resetn)
		$rose(box_valid) |->
			(int'(box.x) + int'(box.width) <= `SCREEN_X) &&
			(int'(box.y) + int'(box.height) <= `SCREEN_Y))
		else $error("box off screen x=%0d y=%0d", box.x, box.y);

endmodule

`default_nettype wire

// ==== verilog/box_raster.sv ====
`default_nettype none

module box_raster (
	input logic clk,
	input logic resetn,
	input pong_pkg::box_req_t box,
	input logic box_valid,
	output logic box_ready,
	output pong_pkg::pixel_t pix,
	output logic pix_valid,
	input logic pix_ready
);
	import pong_pkg::*;

	box_req_t req;
	coord_x_t cnt_x;
	coord_y_t cnt_y;
	logic box_take;
	logic pix_xfer;
	logic row_end;
	logic box_end;

	// walker takes a new box only when idle
	assign box_ready = ~pix_valid;
	assign box_take = box_valid & box_ready;
	assign pix_xfer = pix_valid & pix_ready;

	assign row_end = (cnt_x == coord_x_t'(req.width - 1'b1));
	assign box_end = row_end && (cnt_y == coord_y_t'(req.height - 1'b1));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pix_valid <= 1'b0;
		end else if (box_take) begin
			pix_valid <= 1'b1;
		end else if (pix_xfer && box_end) begin
			pix_valid <= 1'b0;
		end
	end

	// counters only move on a transfer and x runs fastest
	always_ff @(posedge clk) begin
		if (box_take) begin
			req <= box;
			cnt_x <= '0;
			cnt_y <= '0;
		end else if (pix_xfer) begin
			if (row_end) begin
				cnt_x <= '0;
				cnt_y <= cnt_y + 1'b1;
			end else begin
				cnt_x <= cnt_x + 1'b1;
			end
		end
	end

	always_comb begin
		pix.x = req.x + cnt_x;
		pix.y = req.y + cnt_y;
		pix.colour = req.colour;
	end

	a_pix_hold: assert property (@(posedge clk) disable iff (!resetn)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix))
		else $error("pixel changed while stalled");

endmodule

`default_nettype wire

// ==== verilog/pong_render_top.sv ====
`default_nettype none

module pong_render_top (
	input logic clk,
	input logic resetn,
	input logic cfg_we,
	input logic [1:0] cfg_addr,
	input logic [31:0] cfg_wdata,
	input pong_pkg::obj_pos_t objs,
	input logic score,
	output pong_pkg::pixel_t pix,
	output logic pix_valid,
	input logic pix_ready
);
	import pong_pkg::*;

	render_cfg_t cfg;
	box_req_t box;
	logic box_valid;
	logic box_ready;
	logic frame_tick;

	render_regs u_regs (
		.clk(clk),
		.resetn(resetn),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg(cfg)
	);

	frame_timer u_timer (
		.clk(clk),
		.resetn(resetn),
		.frame_period(cfg.frame_period),
		.frame_tick(frame_tick)
	);

	render_sequencer u_seq (
		.clk(clk),
		.resetn(resetn),
		.frame_tick(frame_tick),
		.score(score),
		.objs(objs),
		.cfg(cfg),
		.box(box),
		.box_valid(box_valid),
		.box_ready(box_ready)
	);

	box_raster u_raster (
		.clk(clk),
		.resetn(resetn),
		.box(box),
		.box_valid(box_valid),
		.box_ready(box_ready),
		.pix(pix),
		.pix_valid(pix_valid),
		.pix_ready(pix_ready)
	);

endmodule

`default_nettype wire

// ==== verif/pong_render_tb.sv ====
`default_nettype none

`include "pong_cfg.svh"

module pong_render_tb;
	import pong_pkg::*;

	localparam int START_LIMIT = 1000000;
	localparam int DRAIN_LIMIT = 200000;

	logic clk = 1'b0;
	logic resetn;
	logic cfg_we;
	logic [1:0] cfg_addr;
	logic [31:0] cfg_wdata;
	obj_pos_t objs;
	logic score;
	pixel_t pix;
	logic pix_valid;
	logic pix_ready;

	// reference model of the pixel stream
	box_req_t exp_q[$];
	pixel_t exp_pix = '0;
	logic have_exp = 1'b0;
	coord_x_t ex = '0;
	coord_y_t ey = '0;
	logic xfer_seen = 1'b0;
	int pix_seen = 0;
	int stall_count = 0;
	int pushed_pixels;
	int errors;
	int err_mark;
	int tests;
	int seed;
	obj_pos_t prev_model;
	obj_pos_t cur_model;
	colour_t paddle_col;
	colour_t ball_col;

	pong_render_top dut0 (
		.clk(clk),
		.resetn(resetn),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.objs(objs),
		.score(score),
		.pix(pix),
		.pix_valid(pix_valid),
		.pix_ready(pix_ready)
	);

	always #5 clk = ~clk;

	// display writer takes about three pixels in four
	always @(posedge clk) begin
		pix_ready <= ($random(seed) & 3) != 0;
	end

	always @(posedge clk) begin
		xfer_seen <= resetn && pix_valid && pix_ready;
		if (resetn && pix_valid && !pix_ready) begin
			stall_count <= stall_count + 1;
		end
	end

	// model moves half a cycle after each transfer with x fastest
	always @(negedge clk) begin
		if (xfer_seen && exp_q.size() > 0) begin
			pix_seen++;
			if (ex == exp_q[0].width - 1'b1) begin
				ex = '0;
				if (ey == exp_q[0].height - 1'b1) begin
					ey = '0;
					void'(exp_q.pop_front());
				end else begin
					ey++;
				end
			end else begin
				ex++;
			end
		end
		have_exp = exp_q.size() > 0;
		if (have_exp) begin
			exp_pix.x = exp_q[0].x + ex;
			exp_pix.y = exp_q[0].y + ey;
			exp_pix.colour = exp_q[0].colour;
		end
	end

	a_pix_known: assert property (@(posedge clk) disable iff (!resetn)
		pix_valid && pix_ready |-> have_exp)
		else begin
			errors++;
			$display("pixel transferred with no box left to draw");
		end

	a_pix_x: assert property (@(posedge clk) disable iff (!resetn)
		pix_valid && pix_ready && have_exp |-> pix.x == exp_pix.x)
		else begin
			errors++;
			$display("MISMATCH pix.x got %h expected %h", $sampled(pix.x), exp_pix.x);
		end

	a_pix_y: assert property (@(posedge clk) disable iff (!resetn)
		pix_valid && pix_ready && have_exp |-> pix.y == exp_pix.y)
		else begin
			errors++;
			$display("MISMATCH pix.y got %h expected %h", $sampled(pix.y), exp_pix.y);
		end

	a_pix_colour: assert property (@(posedge clk) disable iff (!resetn)
		pix_valid && pix_ready && have_exp |-> pix.colour == exp_pix.colour)
		else begin
			errors++;
			$display("MISMATCH pix.colour got %h expected %h",
				$sampled(pix.colour), exp_pix.colour);
		end

	a_pix_stall: assert property (@(posedge clk) disable iff (!resetn)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix))
		else begin
			errors++;
			$display("pixel dropped or changed while the writer stalled");
		end

	function automatic box_req_t make_box(input coord_x_t x, input coord_y_t y,
		input coord_x_t w, input coord_y_t h, input colour_t c);
		box_req_t b;
		b.x = x;
		b.y = y;
		b.width = w;
		b.height = h;
		b.colour = c;
		return b;
	endfunction

	function automatic void push_box(input box_req_t b);
		exp_q.push_back(b);
		pushed_pixels += int'(b.width) * int'(b.height);
	endfunction

	function automatic void push_blank();
		push_box(make_box('0, '0, coord_x_t'(`SCREEN_X), coord_y_t'(`SCREEN_Y),
			colour_t'(`BG_COLOUR_RST)));
	endfunction

	// clear at the old place, then draw at the new one
	function automatic void push_frame();
		coord_x_t p2_x;
		colour_t bg;
		p2_x = coord_x_t'(`SCREEN_X - `PADDLE_W);
		bg = colour_t'(`BG_COLOUR_RST);
		push_box(make_box(2, prev_model.paddle1_y, `PADDLE_W, `PADDLE_H, bg));
		push_box(make_box(2, cur_model.paddle1_y, `PADDLE_W, `PADDLE_H, paddle_col));
		push_box(make_box(p2_x, prev_model.paddle2_y, `PADDLE_W, `PADDLE_H, bg));
		push_box(make_box(p2_x, cur_model.paddle2_y, `PADDLE_W, `PADDLE_H, paddle_col));
		push_box(make_box(prev_model.ball_x, prev_model.ball_y, `BALL_SIZE, `BALL_SIZE, bg));
		push_box(make_box(cur_model.ball_x, cur_model.ball_y, `BALL_SIZE, `BALL_SIZE,
			ball_col));
	endfunction

	function automatic obj_pos_t rand_pos();
		obj_pos_t p;
		p.paddle1_y = coord_y_t'(($random(seed) & 32'hffff) % (`SCREEN_Y - `PADDLE_H + 1));
		p.paddle2_y = coord_y_t'(($random(seed) & 32'hffff) % (`SCREEN_Y - `PADDLE_H + 1));
		p.ball_x = coord_x_t'(($random(seed) & 32'hffff) % (`SCREEN_X - `BALL_SIZE + 1));
		p.ball_y = coord_y_t'(($random(seed) & 32'hffff) % (`SCREEN_Y - `BALL_SIZE + 1));
		return p;
	endfunction

	task automatic wait_pixels(input int target, input int limit, input string what);
		int n;
		n = 0;
		while (pix_seen < target && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (pix_seen < target) begin
			$display("timeout waiting for %s, %0d of %0d pixels seen", what, pix_seen, target);
			$display("sim failed");
			$finish;
		end
	endtask

	task automatic write_cfg(input logic [1:0] addr, input logic [31:0] data);
		cfg_we <= 1'b1;
		cfg_addr <= addr;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_we <= 1'b0;
	endtask

	task automatic run_frame(input logic blank_first, input logic new_colours,
		input logic score_event);
		obj_pos_t next_pos;
		int start;
		int blank_px;
		next_pos = rand_pos();
		start = pushed_pixels;
		blank_px = 0;
		if (blank_first) begin
			push_blank();
			blank_px = `SCREEN_X * `SCREEN_Y;
		end
		push_frame();
		// once a pixel is out the positions of this frame are taken
		wait_pixels(start + 1, START_LIMIT, "frame start");
		objs <= next_pos;
		if (score_event) begin
			score <= 1'b1;
			@(posedge clk);
			score <= 1'b0;
		end
		if (new_colours) begin
			// ball draw box is latched as soon as the ball clear starts
			wait_pixels(start + blank_px + 4 * `PADDLE_W * `PADDLE_H + 1, DRAIN_LIMIT,
				"ball clear");
			write_cfg(2'd2, 32'h5);
			write_cfg(2'd3, 32'h3);
			paddle_col = colour_t'(5);
			ball_col = colour_t'(3);
		end
		wait_pixels(pushed_pixels, DRAIN_LIMIT, "frame end");
		prev_model = cur_model;
		cur_model = next_pos;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - err_mark);
		err_mark = errors;
	endtask

	initial begin
		seed = 7;
		errors = 0;
		err_mark = 0;
		tests = 0;
		pushed_pixels = 0;
		resetn = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		score = 1'b0;
		pix_ready = 1'b0;
		prev_model = '0;
		paddle_col = colour_t'(`PADDLE_COLOUR_RST);
		ball_col = colour_t'(`BALL_COLOUR_RST);
		cur_model = rand_pos();
		objs = cur_model;
		// screen is cleared once after reset
		push_blank();
		repeat (8) @(posedge clk);
		resetn <= 1'b1;
		@(posedge clk);
		write_cfg(2'd0, 32'd2000);

		wait_pixels(pushed_pixels, DRAIN_LIMIT, "reset blank");
		end_test("reset blank");

		run_frame(1'b0, 1'b0, 1'b0);
		run_frame(1'b0, 1'b0, 1'b0);
		end_test("frame sequence");

		run_frame(1'b0, 1'b0, 1'b0);
		if (stall_count == 0) begin
			errors++;
			$display("pixel stream was never stalled");
		end
		end_test("back-pressure");

		run_frame(1'b0, 1'b1, 1'b0);
		run_frame(1'b0, 1'b0, 1'b0);
		end_test("configuration");

		run_frame(1'b0, 1'b0, 1'b1);
		run_frame(1'b1, 1'b0, 1'b0);
		end_test("score");

		$display("tests %0d, pixels checked %0d, errors %0d", tests, pix_seen, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verilog
verilog/pong_pkg.sv
verilog/frame_timer.sv
verilog/render_regs.sv
verilog/render_sequencer.sv
verilog/box_raster.sv
verilog/pong_render_top.sv
verif/pong_render_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build with verilator, run, then look for the failure line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module pong_render_tb \
	-Mdir obj_dir -o pong_sim &&
	./obj_dir/pong_sim > sim.log 2>&1 ||
	{ echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
